// ==== src/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// entries in the ring, not a power of two on purpose
`define ROB_DEPTH 12

// rename lanes per cycle
`define ROB_ENQ_W 4

// writeback finish ports
`define ROB_CLR_W 2

// retire lanes per cycle
`define ROB_CMT_W 4

// tag width carried per entry
`define ROB_DATA_W 16

`endif

// ==== src/rob_entry_pkg.sv ====
`include "rob_cfg.svh"

package rob_entry_pkg;

    // tag stored per entry
    typedef logic [`ROB_DATA_W-1:0] rob_data_t;

    // one rename lane on its way into the queue
    typedef struct packed {
        logic      fin;
        rob_data_t data;
    } rob_lane_t;

endpackage

// ==== src/rob_ptr_pkg.sv ====
`include "rob_cfg.svh"

package rob_ptr_pkg;

    // entry index into the ring
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy or lane count, holds ROB_DEPTH itself
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

    // one bit per rename lane
    typedef logic [`ROB_ENQ_W-1:0] enq_mask_t;

    // one bit per retire lane
    typedef logic [`ROB_CMT_W-1:0] cmt_mask_t;

endpackage

// ==== src/enq_compact.sv ====
`timescale 1ns/1ps
`include "rob_cfg.svh"

module enq_compact #(
    // lane payload, widened at the top to carry the finish flag
    parameter type lane_t = rob_entry_pkg::rob_data_t
) (
    input  rob_ptr_pkg::enq_mask_t i_req,
    input  lane_t                  i_data [`ROB_ENQ_W],
    input  rob_ptr_pkg::rob_idx_t  i_slot_idx [`ROB_ENQ_W],
    input  logic                   i_slot_flip [`ROB_ENQ_W],
    output rob_ptr_pkg::enq_mask_t o_req,
    output lane_t                  o_data [`ROB_ENQ_W],
    output rob_ptr_pkg::rob_idx_t  o_alloc_id [`ROB_ENQ_W],
    output logic                   o_ptr_flip [`ROB_ENQ_W]
);
    localparam int SLOT_W = $clog2(`ROB_ENQ_W);

    // packed slot each lane lands in
    logic [SLOT_W-1:0] pos [`ROB_ENQ_W];

    // requesting lanes below each lane
    always_comb begin
        logic [SLOT_W-1:0] run;
        run = '0;
        for (int k = 0; k < `ROB_ENQ_W; k++) begin
            pos[k] = run;
            run = run + SLOT_W'(i_req[k]);
        end
    end

    // scatter requesting lanes into the low slots
    always_comb begin
        o_req = '0;
        for (int s = 0; s < `ROB_ENQ_W; s++) begin
            o_data[s] = '0;
        end
        for (int k = 0; k < `ROB_ENQ_W; k++) begin
            if (i_req[k]) begin
                o_req[pos[k]] = 1'b1;
                o_data[pos[k]] = i_data[k];
            end
        end
    end

    // slot index and flip go back to the lane that took the slot
    for (genvar k = 0; k < `ROB_ENQ_W; k++) begin : g_lane
        assign o_alloc_id[k] = i_slot_idx[pos[k]];
        assign o_ptr_flip[k] = i_slot_flip[pos[k]];
    end

    // run of ones from bit 0, and no lane lost on the way
    always_comb begin
        assert (((o_req & (o_req + 1'b1)) == '0) && ($countones(o_req) == $countones(i_req)))
            else $error("enq_compact: packed mask %b from lanes %b", o_req, i_req);
    end

endmodule

// ==== src/data_que.sv ====
`timescale 1ns/1ps
`include "rob_cfg.svh"

module data_que (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_stall,
    input  logic                     i_enq_vld,
    input  rob_ptr_pkg::enq_mask_t   i_enq_req,
    input  rob_ptr_pkg::enq_mask_t   i_enq_fin,
    input  rob_entry_pkg::rob_data_t i_enq_data [`ROB_ENQ_W],
    output logic                     o_can_enq,
    output rob_ptr_pkg::rob_idx_t    o_slot_idx [`ROB_ENQ_W],
    output logic                     o_slot_flip [`ROB_ENQ_W],
    input  logic [`ROB_CLR_W-1:0]    i_clr_vld,
    input  rob_ptr_pkg::rob_idx_t    i_clr_idx [`ROB_CLR_W],
    output rob_ptr_pkg::cmt_mask_t   o_cmt_vld,
    output rob_ptr_pkg::rob_idx_t    o_cmt_idx [`ROB_CMT_W],
    output rob_entry_pkg::rob_data_t o_cmt_data [`ROB_CMT_W]
);
    localparam rob_ptr_pkg::rob_cnt_t DEPTH = rob_ptr_pkg::rob_cnt_t'(`ROB_DEPTH);

    // storage and per-entry state
    rob_entry_pkg::rob_data_t buffer [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]    vld_bits;
    logic [`ROB_DEPTH-1:0]    fin_bits;
    rob_ptr_pkg::rob_cnt_t    count;

    // one tail per lane, one head per retire lane
    rob_ptr_pkg::rob_idx_t enq_ptr [`ROB_ENQ_W];
    logic                  enq_flip [`ROB_ENQ_W];
    rob_ptr_pkg::rob_idx_t head_ptr [`ROB_CMT_W];
    rob_ptr_pkg::rob_idx_t enq_ptr_nxt [`ROB_ENQ_W];
    rob_ptr_pkg::rob_idx_t head_ptr_nxt [`ROB_CMT_W];

    rob_ptr_pkg::rob_cnt_t  req_num;
    rob_ptr_pkg::rob_cnt_t  free_num;
    rob_ptr_pkg::rob_cnt_t  enq_num;
    rob_ptr_pkg::rob_cnt_t  cmt_num;
    rob_ptr_pkg::enq_mask_t enq_wr;
    logic                   enq_acc;

    // advance a pointer around the ring, n is below DEPTH
    function automatic rob_ptr_pkg::rob_idx_t ring_step(
        input rob_ptr_pkg::rob_idx_t ptr,
        input rob_ptr_pkg::rob_cnt_t n
    );
        rob_ptr_pkg::rob_cnt_t sum;
        sum = rob_ptr_pkg::rob_cnt_t'(ptr) + n;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return rob_ptr_pkg::rob_idx_t'(sum);
    endfunction

    // enqueue acceptance
    assign req_num = rob_ptr_pkg::rob_cnt_t'($countones(i_enq_req));
    assign free_num = DEPTH - count;
    assign o_can_enq = req_num <= free_num;
    assign enq_acc = i_enq_vld && o_can_enq;
    assign enq_wr = enq_acc ? i_enq_req : '0;
    assign enq_num = enq_acc ? req_num : '0;

    assign o_slot_idx = enq_ptr;
    assign o_slot_flip = enq_flip;

    // in-order window, stops at the first unfinished entry
    always_comb begin
        logic run;
        run = !i_stall;
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            run = run && vld_bits[head_ptr[k]] && fin_bits[head_ptr[k]];
            o_cmt_vld[k] = run;
        end
    end

    assign cmt_num = rob_ptr_pkg::rob_cnt_t'($countones(o_cmt_vld));

    for (genvar k = 0; k < `ROB_CMT_W; k++) begin : g_cmt
        assign o_cmt_idx[k] = head_ptr[k];
        assign o_cmt_data[k] = buffer[head_ptr[k]];
    end

    always_comb begin
        for (int j = 0; j < `ROB_ENQ_W; j++) begin
            enq_ptr_nxt[j] = ring_step(enq_ptr[j], enq_num);
        end
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            head_ptr_nxt[k] = ring_step(head_ptr[k], cmt_num);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            vld_bits <= '0;
            fin_bits <= '0;
            for (int j = 0; j < `ROB_ENQ_W; j++) begin
                enq_ptr[j] <= rob_ptr_pkg::rob_idx_t'(j);
                enq_flip[j] <= 1'b0;
            end
            for (int k = 0; k < `ROB_CMT_W; k++) begin
                head_ptr[k] <= rob_ptr_pkg::rob_idx_t'(k);
            end
        end else begin
            count <= count + enq_num - cmt_num;

            for (int j = 0; j < `ROB_ENQ_W; j++) begin
                enq_ptr[j] <= enq_ptr_nxt[j];
                // a smaller next index means the lane went past the end
                if (enq_ptr_nxt[j] < enq_ptr[j]) begin
                    enq_flip[j] <= !enq_flip[j];
                end
                if (enq_wr[j]) begin
                    vld_bits[enq_ptr[j]] <= 1'b1;
                    fin_bits[enq_ptr[j]] <= i_enq_fin[j];
                end
            end

            // writeback finish
            for (int c = 0; c < `ROB_CLR_W; c++) begin
                if (i_clr_vld[c]) begin
                    fin_bits[i_clr_idx[c]] <= 1'b1;
                end
            end

            // retire last so it wins over a late finish
            for (int k = 0; k < `ROB_CMT_W; k++) begin
                head_ptr[k] <= head_ptr_nxt[k];
                if (o_cmt_vld[k]) begin
                    vld_bits[head_ptr[k]] <= 1'b0;
                    fin_bits[head_ptr[k]] <= 1'b0;
                end
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        for (int j = 0; j < `ROB_ENQ_W; j++) begin
            if (enq_wr[j]) begin
                buffer[enq_ptr[j]] <= i_enq_data[j];
            end
        end
    end

    // occupancy bound
    a_count_le_depth: assert property (
        @(posedge clk) disable iff (rst) count <= DEPTH
    ) else $error("data_que: occupancy %0d above depth", count);

    // new entries appear only after an accepted cycle
    a_no_write_unaccepted: assert property (
        @(posedge clk) disable iff (rst)
        !enq_acc |=> ((vld_bits & ~$past(vld_bits)) == '0)
    ) else $error("data_que: entry written without acceptance");

    for (genvar c = 0; c < `ROB_CLR_W; c++) begin : g_clr_chk
        a_clr_valid: assert property (
            @(posedge clk) disable iff (rst)
            i_clr_vld[c] |-> vld_bits[i_clr_idx[c]]
        ) else $error("data_que: finish on empty entry %0d", i_clr_idx[c]);
    end

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_stall,
    input  logic                     i_enq_vld,
    input  rob_ptr_pkg::enq_mask_t   i_enq_req,
    input  rob_ptr_pkg::enq_mask_t   i_enq_fin,
    input  rob_entry_pkg::rob_data_t i_enq_data [`ROB_ENQ_W],
    output logic                     o_can_enq,
    output rob_ptr_pkg::rob_idx_t    o_alloc_id [`ROB_ENQ_W],
    output logic                     o_ptr_flip [`ROB_ENQ_W],
    input  logic [`ROB_CLR_W-1:0]    i_clr_vld,
    input  rob_ptr_pkg::rob_idx_t    i_clr_idx [`ROB_CLR_W],
    output rob_ptr_pkg::cmt_mask_t   o_cmt_vld,
    output rob_ptr_pkg::rob_idx_t    o_cmt_idx [`ROB_CMT_W],
    output rob_entry_pkg::rob_data_t o_cmt_data [`ROB_CMT_W]
);
    rob_entry_pkg::rob_lane_t lane_in [`ROB_ENQ_W];
    rob_entry_pkg::rob_lane_t lane_pk [`ROB_ENQ_W];
    rob_ptr_pkg::enq_mask_t   pk_req;
    rob_ptr_pkg::enq_mask_t   pk_fin;
    rob_entry_pkg::rob_data_t pk_data [`ROB_ENQ_W];
    rob_ptr_pkg::rob_idx_t    slot_idx [`ROB_ENQ_W];
    logic                     slot_flip [`ROB_ENQ_W];

    // finish flag rides along with the tag through the packing
    for (genvar k = 0; k < `ROB_ENQ_W; k++) begin : g_lane
        assign lane_in[k] = {i_enq_fin[k], i_enq_data[k]};
        assign pk_fin[k] = lane_pk[k].fin;
        assign pk_data[k] = lane_pk[k].data;
    end

    enq_compact #(
        .lane_t      (rob_entry_pkg::rob_lane_t)
    ) u_enq_compact (
        .i_req       (i_enq_req),
        .i_data      (lane_in),
        .i_slot_idx  (slot_idx),
        .i_slot_flip (slot_flip),
        .o_req       (pk_req),
        .o_data      (lane_pk),
        .o_alloc_id  (o_alloc_id),
        .o_ptr_flip  (o_ptr_flip)
    );

    data_que u_data_que (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (i_stall),
        .i_enq_vld   (i_enq_vld),
        .i_enq_req   (pk_req),
        .i_enq_fin   (pk_fin),
        .i_enq_data  (pk_data),
        .o_can_enq   (o_can_enq),
        .o_slot_idx  (slot_idx),
        .o_slot_flip (slot_flip),
        .i_clr_vld   (i_clr_vld),
        .i_clr_idx   (i_clr_idx),
        .o_cmt_vld   (o_cmt_vld),
        .o_cmt_idx   (o_cmt_idx),
        .o_cmt_data  (o_cmt_data)
    );

endmodule

// ==== verification/rob_model.svh ====
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// expected queue contents, oldest entry first
rob_entry_pkg::rob_data_t m_tag [$];
logic                     m_fin [$];
logic                     m_flip [$];
int                       m_idx [$];

// entries allocated and retired since reset
int alloc_total;
int retire_total;

function automatic void model_reset();
    m_tag.delete();
    m_fin.delete();
    m_flip.delete();
    m_idx.delete();
    alloc_total = 0;
    retire_total = 0;
endfunction

function automatic int model_free();
    return `ROB_DEPTH - m_idx.size();
endfunction

// index of the n-th packed slot counted from the tail
function automatic int model_slot_idx(input int s);
    return (alloc_total + s) % `ROB_DEPTH;
endfunction

// flip toggles on every full turn of the ring
function automatic logic model_slot_flip(input int s);
    return (((alloc_total + s) / `ROB_DEPTH) % 2) == 1;
endfunction

// finished run from the head, cut at the commit lane count
function automatic int model_cmt_num(input logic hold);
    int n;
    n = 0;
    if (!hold) begin
        while (n < `ROB_CMT_W && n < m_idx.size() && m_fin[n]) begin
            n++;
        end
    end
    return n;
endfunction

function automatic void model_enqueue(input rob_entry_pkg::rob_data_t tag, input logic fin);
    m_tag.push_back(tag);
    m_fin.push_back(fin);
    m_flip.push_back(model_slot_flip(0));
    m_idx.push_back(model_slot_idx(0));
    alloc_total++;
endfunction

function automatic void model_finish(input int idx);
    for (int i = 0; i < m_idx.size(); i++) begin
        if (m_idx[i] == idx) begin
            m_fin[i] = 1'b1;
        end
    end
endfunction

function automatic void model_retire(input int n);
    for (int i = 0; i < n; i++) begin
        void'(m_tag.pop_front());
        void'(m_fin.pop_front());
        void'(m_flip.pop_front());
        void'(m_idx.pop_front());
    end
    retire_total += n;
endfunction

`endif

// ==== verification/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_tb;
    localparam int LEN_SPARSE = 40;
    localparam int LEN_FULL = 30;
    localparam int LEN_STALL = 40;
    localparam int LEN_WRAP = 36;
    localparam int CYCLE_LIMIT = 8 + LEN_SPARSE + LEN_FULL + LEN_STALL + LEN_WRAP + 200;

    logic                     clk;
    logic                     rst;
    logic                     stall;
    logic                     enq_vld;
    rob_ptr_pkg::enq_mask_t   enq_req;
    rob_ptr_pkg::enq_mask_t   enq_fin;
    rob_entry_pkg::rob_data_t enq_data [`ROB_ENQ_W];
    logic                     can_enq;
    rob_ptr_pkg::rob_idx_t    alloc_id [`ROB_ENQ_W];
    logic                     ptr_flip [`ROB_ENQ_W];
    logic [`ROB_CLR_W-1:0]    clr_vld;
    rob_ptr_pkg::rob_idx_t    clr_idx [`ROB_CLR_W];
    rob_ptr_pkg::cmt_mask_t   cmt_vld;
    rob_ptr_pkg::rob_idx_t    cmt_idx [`ROB_CMT_W];
    rob_entry_pkg::rob_data_t cmt_data [`ROB_CMT_W];

    logic [15:0] lfsr_state;
    int          cycle_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_cnt;
    int          test_err_base;

    `include "rob_model.svh"

    rob_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_enq_vld  (enq_vld),
        .i_enq_req  (enq_req),
        .i_enq_fin  (enq_fin),
        .i_enq_data (enq_data),
        .o_can_enq  (can_enq),
        .o_alloc_id (alloc_id),
        .o_ptr_flip (ptr_flip),
        .i_clr_vld  (clr_vld),
        .i_clr_idx  (clr_idx),
        .o_cmt_vld  (cmt_vld),
        .o_cmt_idx  (cmt_idx),
        .o_cmt_data (cmt_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic test_done(input string name);
        test_cnt++;
        $display("%s finished with %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // drive one cycle and check it against the model before the edge updates it
    task automatic step(input rob_ptr_pkg::enq_mask_t req_mask, input logic lane_vld,
                        input rob_ptr_pkg::enq_mask_t fin_mask, input logic hold,
                        input int clr_num);
        int                       cand [$];
        int                       pick [$];
        int                       n_cmt;
        int                       slot;
        logic                     acc;
        rob_entry_pkg::rob_data_t tags [`ROB_ENQ_W];
        @(posedge clk);
        #1;
        // only valid unfinished entries may be finished
        for (int i = 0; i < m_idx.size(); i++) begin
            if (!m_fin[i]) begin
                cand.push_back(m_idx[i]);
            end
        end
        for (int c = 0; c < `ROB_CLR_W; c++) begin
            clr_vld[c] = 1'b0;
            clr_idx[c] = '0;
            if (c < clr_num && cand.size() > 0) begin
                slot = int'(rand_bits(4)) % cand.size();
                clr_vld[c] = 1'b1;
                clr_idx[c] = rob_ptr_pkg::rob_idx_t'(cand[slot]);
                pick.push_back(cand[slot]);
                cand.delete(slot);
            end
        end
        for (int k = 0; k < `ROB_ENQ_W; k++) begin
            tags[k] = rob_entry_pkg::rob_data_t'(rand_bits(16));
            enq_data[k] = tags[k];
        end
        enq_req = req_mask;
        enq_vld = lane_vld;
        enq_fin = fin_mask;
        stall = hold;
        #2;
        acc = lane_vld && ($countones(req_mask) <= model_free());
        check_val("o_can_enq", 32'(can_enq), 32'($countones(req_mask) <= model_free()));
        n_cmt = model_cmt_num(hold);
        check_val("o_cmt_vld", 32'(cmt_vld), (1 << n_cmt) - 1);
        for (int k = 0; k < n_cmt; k++) begin
            check_val($sformatf("o_cmt_idx[%0d]", k), 32'(cmt_idx[k]), m_idx[k]);
            check_val($sformatf("o_cmt_data[%0d]", k), 32'(cmt_data[k]), 32'(m_tag[k]));
        end
        model_retire(n_cmt);
        foreach (pick[p]) begin
            model_finish(pick[p]);
        end
        if (acc) begin
            slot = m_idx.size();
            for (int k = 0; k < `ROB_ENQ_W; k++) begin
                if (req_mask[k]) begin
                    model_enqueue(tags[k], fin_mask[k]);
                end
            end
            // new tail entries in lane order
            for (int k = 0; k < `ROB_ENQ_W; k++) begin
                if (req_mask[k]) begin
                    check_val($sformatf("o_alloc_id[%0d]", k), 32'(alloc_id[k]),
                              m_idx[slot]);
                    check_val($sformatf("o_ptr_flip[%0d]", k), 32'(ptr_flip[k]),
                              32'(m_flip[slot]));
                    slot++;
                end
            end
        end
    endtask

    // finish and retire whatever is left
    task automatic drain();
        while (m_idx.size() > 0) begin
            step('0, 1'b0, '0, 1'b0, `ROB_CLR_W);
        end
    endtask

    initial begin
        rob_ptr_pkg::enq_mask_t fill [7];
        rst = 1'b1;
        stall = 1'b0;
        enq_vld = 1'b0;
        enq_req = '0;
        enq_fin = '0;
        clr_vld = '0;
        for (int k = 0; k < `ROB_ENQ_W; k++) begin
            enq_data[k] = '0;
        end
        for (int c = 0; c < `ROB_CLR_W; c++) begin
            clr_idx[c] = '0;
        end
        lfsr_state = 16'd19058;
        cycle_cnt = 0;
        check_cnt = 0;
        err_cnt = 0;
        test_cnt = 0;
        test_err_base = 0;
        model_reset();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // sparse masks with random finishes
        for (int i = 0; i < LEN_SPARSE; i++) begin
            step(rand_bits(4), rand_bits(3) != 0, rand_bits(4), 1'b0, int'(rand_bits(2)) % 3);
        end
        test_done("sparse_lanes");

        // fill to exactly the depth while nothing can retire
        fill = '{4'b1111, 4'b1111, 4'b1011, 4'b1111, 4'b0101, 4'b1000, 4'b0001};
        drain();
        foreach (fill[i]) begin
            step(fill[i], 1'b1, '0, 1'b1, 0);
        end
        drain();
        test_done("full_buffer");

        // commit prefix under random stall
        for (int i = 0; i < LEN_STALL; i++) begin
            step(rand_bits(4), 1'b1, rand_bits(4), rand_bits(2) == 0, int'(rand_bits(2)) % 3);
        end
        test_done("commit_stall");

        // finished at enqueue over several turns of the ring
        for (int i = 0; i < LEN_WRAP; i++) begin
            step(rand_bits(4) | 4'b0001, 1'b1, 4'b1111, 1'b0, 0);
        end
        test_done("pointer_wrap");

        $display("tests %0d, checks %0d, errors %0d, retired %0d",
                 test_cnt, check_cnt, err_cnt, retire_total);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
+incdir+verification
src/rob_entry_pkg.sv
src/rob_ptr_pkg.sv
src/enq_compact.sv
src/data_que.sv
src/rob_top.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the reorder buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f flist.f \
    --top-module rob_tb

# keep running to the search even if the simulator exits nonzero
./obj_dir/Vrob_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
